// File: hw/alu32.sv
`timescale 1ns/1ns

module alu32 (
  input  cpu_pkg::ctrl_t             ctrl,
  input  logic [cpu_pkg::DATA_W-1:0] read_data1,
  input  logic [cpu_pkg::DATA_W-1:0] read_data2,
  output logic [cpu_pkg::DATA_W-1:0] alu_result,
  output logic                       take
);

  localparam int SH_W = $clog2(cpu_pkg::DATA_W);

  logic [cpu_pkg::DATA_W-1:0] op_a;
  logic [cpu_pkg::DATA_W-1:0] op_b;
  logic                       equal;

  // ========================================================================
  // Operand selection
  // ========================================================================
  assign op_a = read_data1;
  assign op_b = ctrl.use_imm ? ctrl.imm : read_data2;  // Loads and stores add the offset

  // ========================================================================
  // Arithmetic and logic
  // ========================================================================
  always_comb begin
    case (ctrl.alu_op)
      cpu_pkg::ALU_ADD: alu_result = op_a + op_b;
      cpu_pkg::ALU_SUB: alu_result = op_a - op_b;
      cpu_pkg::ALU_AND: alu_result = op_a & op_b;
      cpu_pkg::ALU_OR:  alu_result = op_a | op_b;
      cpu_pkg::ALU_XOR: alu_result = op_a ^ op_b;
      cpu_pkg::ALU_SLL: alu_result = op_a << op_b[SH_W-1:0];
      cpu_pkg::ALU_SRL: alu_result = op_a >> op_b[SH_W-1:0];
      default:          alu_result = op_a;
    endcase
  end

  // ========================================================================
  // Branch condition
  // ========================================================================
  // Compare always uses the register operand, imm holds the PC offset
  assign equal = (read_data1 == read_data2);

  always_comb begin
    take = 1'b0;
    if (ctrl.is_jump) begin
      take = 1'b1;
    end else if (ctrl.is_branch) begin
      take = ctrl.is_bne ? !equal : equal;
    end
  end

endmodule

// File: hw/cpu_pkg.sv
package cpu_pkg;

  localparam int DATA_W = 32;  // Datapath width
  localparam int REG_AW = 5;   // Register address width

  // ========================================================================
  // Instruction encoding
  // ========================================================================

  // Major opcode, instruction bits 30:25
  typedef enum logic [5:0] {
    OP_LWI  = 6'b000010,
    OP_SWI  = 6'b001010,
    OP_ALU  = 6'b100000,
    OP_MOVI = 6'b100010,
    OP_J    = 6'b100100,
    OP_BEQ  = 6'b100110,  // Bit 14 set gives BNE
    OP_ADDI = 6'b101000,
    OP_ORI  = 6'b101100
  } opcode_e;

  // Sub-opcodes of OP_ALU, instruction bits 4:0
  localparam logic [4:0] FN_ADD  = 5'b00000;
  localparam logic [4:0] FN_SUB  = 5'b00001;
  localparam logic [4:0] FN_AND  = 5'b00010;
  localparam logic [4:0] FN_XOR  = 5'b00011;
  localparam logic [4:0] FN_OR   = 5'b00100;
  localparam logic [4:0] FN_SLLI = 5'b01000;
  localparam logic [4:0] FN_SRLI = 5'b01001;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6
  } alu_op_e;

  // ========================================================================
  // Decoded control, registered at the end of DECODE
  // ========================================================================
  typedef struct packed {
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    alu_op_e           alu_op;
    logic              use_imm;
    logic [DATA_W-1:0] imm;        // Already extended
    logic              is_load;
    logic              is_store;
    logic              is_branch;
    logic              is_bne;
    logic              is_jump;
    logic              writes_rd;
  } ctrl_t;

endpackage

// File: hw/ir_controller.sv
`timescale 1ns/1ns

module ir_controller #(
  parameter int IM_AW = 10,
  parameter int INS_W = 32
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       load_done,
  input  logic                       eop,
  input  logic [IM_AW-1:0]           pc,
  input  logic [cpu_pkg::DATA_W-1:0] im_rdata,
  input  logic                       take,
  output logic                       im_read,
  output logic                       dm_read,
  output logic                       dm_write,
  output logic                       reg_write,
  output logic                       pc_step,
  output logic                       pc_jump,
  output logic                       run,
  output logic                       done,
  output cpu_pkg::ctrl_t             ctrl,
  output logic [INS_W-1:0]           ins_cnt
);

  typedef enum logic [2:0] {
    S_IDLE, S_FETCH, S_DECODE, S_EXEC, S_MEM, S_WB, S_DONE
  } state_e;

  state_e           state;
  state_e           state_nxt;
  cpu_pkg::ctrl_t   dec;
  cpu_pkg::opcode_e opcode;
  logic             exec_last;

  // ========================================================================
  // Decode, im_rdata is valid during DECODE
  // ========================================================================
  assign opcode = cpu_pkg::opcode_e'(im_rdata[30:25]);

  always_comb begin
    dec     = '0;
    dec.rd  = im_rdata[24:20];
    dec.rs1 = im_rdata[19:15];
    dec.rs2 = im_rdata[14:10];
    case (opcode)
      cpu_pkg::OP_ALU: begin
        dec.writes_rd = 1'b1;
        case (im_rdata[4:0])
          cpu_pkg::FN_ADD: dec.alu_op = cpu_pkg::ALU_ADD;
          cpu_pkg::FN_SUB: dec.alu_op = cpu_pkg::ALU_SUB;
          cpu_pkg::FN_AND: dec.alu_op = cpu_pkg::ALU_AND;
          cpu_pkg::FN_OR:  dec.alu_op = cpu_pkg::ALU_OR;
          cpu_pkg::FN_XOR: dec.alu_op = cpu_pkg::ALU_XOR;
          cpu_pkg::FN_SLLI, cpu_pkg::FN_SRLI: begin
            dec.alu_op  = im_rdata[0] ? cpu_pkg::ALU_SRL : cpu_pkg::ALU_SLL;
            dec.use_imm = 1'b1;
            dec.imm     = {27'b0, im_rdata[14:10]};  // imm5 shift amount
          end
          default: dec.writes_rd = 1'b0;  // Unknown sub-op runs as no-op
        endcase
      end
      cpu_pkg::OP_ADDI, cpu_pkg::OP_LWI: begin
        dec.writes_rd = 1'b1;
        dec.is_load   = (opcode == cpu_pkg::OP_LWI);
        dec.use_imm   = 1'b1;
        dec.imm       = {{17{im_rdata[14]}}, im_rdata[14:0]};
      end
      cpu_pkg::OP_ORI: begin
        dec.writes_rd = 1'b1;
        dec.alu_op    = cpu_pkg::ALU_OR;
        dec.use_imm   = 1'b1;
        dec.imm       = {17'b0, im_rdata[14:0]};
      end
      cpu_pkg::OP_MOVI: begin
        dec.writes_rd = 1'b1;
        dec.rs1       = '0;  // r0 + imm20
        dec.use_imm   = 1'b1;
        dec.imm       = {{12{im_rdata[19]}}, im_rdata[19:0]};
      end
      cpu_pkg::OP_SWI: begin
        dec.is_store = 1'b1;
        dec.rs2      = im_rdata[24:20];  // Store data
        dec.use_imm  = 1'b1;
        dec.imm      = {{17{im_rdata[14]}}, im_rdata[14:0]};
      end
      cpu_pkg::OP_BEQ: begin
        dec.is_branch = 1'b1;
        dec.is_bne    = im_rdata[14];
        dec.rs2       = im_rdata[24:20];
        dec.imm       = {{18{im_rdata[13]}}, im_rdata[13:0]};
      end
      cpu_pkg::OP_J: begin
        dec.is_jump = 1'b1;
        dec.imm     = {{8{im_rdata[23]}}, im_rdata[23:0]};
      end
      default: ;
    endcase
  end

  // ========================================================================
  // Multicycle sequencer
  // ========================================================================
  assign exec_last = !(ctrl.is_load || ctrl.is_store || ctrl.writes_rd);

  always_comb begin
    state_nxt = state;
    im_read   = 1'b0;
    dm_read   = 1'b0;
    dm_write  = 1'b0;
    reg_write = 1'b0;
    pc_step   = 1'b0;
    pc_jump   = 1'b0;
    case (state)
      S_IDLE: if (load_done) state_nxt = S_FETCH;
      S_FETCH: begin
        if (eop) begin
          state_nxt = S_DONE;
        end else begin
          im_read   = 1'b1;
          state_nxt = S_DECODE;
        end
      end
      S_DECODE: state_nxt = S_EXEC;
      S_EXEC: begin
        if (exec_last) begin  // Branches, jumps and no-ops end here
          pc_step   = 1'b1;
          pc_jump   = take;
          state_nxt = S_FETCH;
        end else if (ctrl.is_load || ctrl.is_store) begin
          state_nxt = S_MEM;
        end else begin
          state_nxt = S_WB;
        end
      end
      S_MEM: begin
        dm_read  = ctrl.is_load;
        dm_write = ctrl.is_store;
        if (ctrl.is_store) begin
          pc_step   = 1'b1;
          state_nxt = S_FETCH;
        end else begin
          state_nxt = S_WB;
        end
      end
      S_WB: begin
        reg_write = ctrl.writes_rd;
        pc_step   = 1'b1;
        state_nxt = S_FETCH;
      end
      default: ;  // DONE holds until reset
    endcase
  end

  assign run  = (state != S_IDLE) && (state != S_DONE);
  assign done = (state == S_DONE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= S_IDLE;
      ctrl    <= '0;
      ins_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (state == S_DECODE) ctrl <= dec;
      if (pc_step) ins_cnt <= ins_cnt + 1'b1;
    end
  end

  a_dm_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !(dm_read && dm_write));

  // PC in pc_tick moves only on our step pulse
  a_pc_hold: assert property (@(posedge clk) disable iff (!arst_n)
    !pc_step |=> $stable(pc));

endmodule

// File: hw/pc_tick.sv
`timescale 1ns/1ns

module pc_tick #(
  parameter int IM_AW   = 10,
  parameter int CYCLE_W = 64
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       run,
  input  logic                       pc_step,
  input  logic                       pc_jump,
  input  logic [cpu_pkg::DATA_W-1:0] jump_off,
  input  logic [IM_AW-1:0]           prog_len,
  output logic [IM_AW-1:0]           pc,
  output logic                       eop,
  output logic [CYCLE_W-1:0]         cycle_cnt
);

  assign eop = (pc == prog_len);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc        <= '0;
      cycle_cnt <= '0;
    end else begin
      if (run) cycle_cnt <= cycle_cnt + 1'b1;
      if (pc_step) begin
        if (pc_jump) begin
          pc <= pc + jump_off[IM_AW-1:0];  // Relative, wraps in IM space
        end else begin
          pc <= pc + 1'b1;
        end
      end
    end
  end

  // The controller must check eop in FETCH before issuing anything
  a_no_step_at_end: assert property (@(posedge clk) disable iff (!arst_n)
    pc_step |-> !eop);

endmodule

// File: hw/regfile.sv
`timescale 1ns/1ns

module regfile (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       write,
  input  cpu_pkg::ctrl_t             ctrl,
  input  logic [cpu_pkg::DATA_W-1:0] write_data,
  output logic [cpu_pkg::DATA_W-1:0] read_data1,
  output logic [cpu_pkg::DATA_W-1:0] read_data2
);

  localparam int NREG = 2 ** cpu_pkg::REG_AW;

  logic [cpu_pkg::DATA_W-1:0] regs [NREG];

  // r0 is hardwired to zero on both ports
  assign read_data1 = (ctrl.rs1 == '0) ? '0 : regs[ctrl.rs1];
  assign read_data2 = (ctrl.rs2 == '0) ? '0 : regs[ctrl.rs2];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (write && ctrl.rd != '0) begin
      regs[ctrl.rd] <= write_data;
    end
  end

endmodule

// File: hw/rom_loader.sv
`timescale 1ns/1ns

module rom_loader #(
  parameter int ROM_AW = 11,
  parameter int IM_AW  = 10
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       system_enable,
  input  logic [cpu_pkg::DATA_W-1:0] rom_data,
  output logic                       rom_read,
  output logic [ROM_AW-1:0]          rom_addr,
  output logic                       im_write,
  output logic [IM_AW-1:0]           im_addr,
  output logic [cpu_pkg::DATA_W-1:0] im_wdata,
  output logic                       loading,
  output logic                       load_done,
  output logic [IM_AW-1:0]           prog_len
);

  typedef enum logic [2:0] {S_IDLE, S_LEN, S_COPY, S_FIN, S_HOLD} state_e;

  state_e            state;
  logic [ROM_AW-1:0] rd_addr;
  logic [IM_AW-1:0]  wr_addr;
  logic [IM_AW-1:0]  len_in;

  assign len_in   = rom_data[IM_AW-1:0];  // ROM word 0 arrives in S_LEN
  assign rom_addr = rd_addr;
  assign im_addr  = wr_addr;               // Trails rd_addr by one word
  assign im_wdata = rom_data;

  always_comb begin
    rom_read  = 1'b0;
    im_write  = 1'b0;
    load_done = 1'b0;
    case (state)
      S_IDLE: rom_read = system_enable;
      S_LEN:  rom_read = (len_in != '0);
      S_COPY: begin
        rom_read = (rd_addr <= ROM_AW'(prog_len));
        im_write = 1'b1;
      end
      S_FIN:  load_done = 1'b1;
      default: ;
    endcase
  end

  assign loading = (state == S_IDLE && system_enable) || state == S_LEN ||
                   state == S_COPY || state == S_FIN;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= S_IDLE;
      rd_addr  <= '0;
      wr_addr  <= '0;
      prog_len <= '0;
    end else begin
      if (rom_read) rd_addr <= rd_addr + 1'b1;
      if (im_write) wr_addr <= wr_addr + 1'b1;
      case (state)
        S_IDLE: if (system_enable) state <= S_LEN;
        S_LEN: begin
          prog_len <= len_in;
          state    <= (len_in == '0) ? S_FIN : S_COPY;
        end
        S_COPY: if (wr_addr == prog_len - 1'b1) state <= S_FIN;
        S_FIN:  state <= S_HOLD;  // No reload until reset
        default: ;
      endcase
    end
  end

  // IM writes stay inside the program image
  a_write_in_load: assert property (@(posedge clk) disable iff (!arst_n)
    im_write |-> loading && (im_addr < prog_len));

endmodule

// File: hw/top.sv
`timescale 1ns/1ns

module top #(
  parameter int IM_AW   = 10,
  parameter int DM_AW   = 15,
  parameter int ROM_AW  = 11,
  parameter int CYCLE_W = 64,
  parameter int INS_W   = 32
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       system_enable,
  output logic                       rom_read,
  output logic [ROM_AW-1:0]          rom_addr,
  input  logic [cpu_pkg::DATA_W-1:0] rom_data,
  output logic                       im_read,
  output logic                       im_write,
  output logic [IM_AW-1:0]           im_addr,
  output logic [cpu_pkg::DATA_W-1:0] im_wdata,
  input  logic [cpu_pkg::DATA_W-1:0] im_rdata,
  output logic                       dm_read,
  output logic                       dm_write,
  output logic [DM_AW-1:0]           dm_addr,
  output logic [cpu_pkg::DATA_W-1:0] dm_wdata,
  input  logic [cpu_pkg::DATA_W-1:0] dm_rdata,
  output logic                       done,
  output logic [CYCLE_W-1:0]         cycle_cnt,
  output logic [INS_W-1:0]           ins_cnt
);

  logic                       loading;
  logic                       load_done;
  logic [IM_AW-1:0]           prog_len;
  logic                       ld_im_write;
  logic [IM_AW-1:0]           ld_im_addr;
  logic [IM_AW-1:0]           pc;
  logic                       eop;
  logic                       ctl_im_read;
  logic                       ctl_run;
  logic                       reg_write;
  logic                       pc_step;
  logic                       pc_jump;
  logic                       take;
  cpu_pkg::ctrl_t             ctrl;
  logic [cpu_pkg::DATA_W-1:0] read_data1;
  logic [cpu_pkg::DATA_W-1:0] read_data2;
  logic [cpu_pkg::DATA_W-1:0] alu_result;
  logic [cpu_pkg::DATA_W-1:0] wb_data;

  // IM port belongs to the loader during the load phase
  assign im_read  = loading ? 1'b0 : ctl_im_read;
  assign im_write = loading ? ld_im_write : 1'b0;
  assign im_addr  = loading ? ld_im_addr : pc;

  assign dm_addr  = alu_result[DM_AW-1:0];
  assign dm_wdata = read_data2;
  assign wb_data  = ctrl.is_load ? dm_rdata : alu_result;

  rom_loader #(.ROM_AW(ROM_AW), .IM_AW(IM_AW)) rom_loader_i (
    .clk(clk), .arst_n(arst_n), .system_enable(system_enable),
    .rom_data(rom_data), .rom_read(rom_read), .rom_addr(rom_addr),
    .im_write(ld_im_write), .im_addr(ld_im_addr), .im_wdata(im_wdata),
    .loading(loading), .load_done(load_done), .prog_len(prog_len));

  pc_tick #(.IM_AW(IM_AW), .CYCLE_W(CYCLE_W)) pc_tick_i (
    .clk(clk), .arst_n(arst_n), .run(ctl_run | loading), .pc_step(pc_step),
    .pc_jump(pc_jump), .jump_off(ctrl.imm), .prog_len(prog_len),
    .pc(pc), .eop(eop), .cycle_cnt(cycle_cnt));

  ir_controller #(.IM_AW(IM_AW), .INS_W(INS_W)) ir_controller_i (
    .clk(clk), .arst_n(arst_n), .load_done(load_done), .eop(eop), .pc(pc),
    .im_rdata(im_rdata), .take(take), .im_read(ctl_im_read),
    .dm_read(dm_read), .dm_write(dm_write), .reg_write(reg_write),
    .pc_step(pc_step), .pc_jump(pc_jump), .run(ctl_run), .done(done),
    .ctrl(ctrl), .ins_cnt(ins_cnt));

  regfile regfile_i (
    .clk(clk), .arst_n(arst_n), .write(reg_write), .ctrl(ctrl),
    .write_data(wb_data), .read_data1(read_data1), .read_data2(read_data2));

  alu32 alu32_i (
    .ctrl(ctrl), .read_data1(read_data1), .read_data2(read_data2),
    .alu_result(alu_result), .take(take));

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 --top-module tb_top \
  -f verilog.f --Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q -F '*** PASSED ***' "$LOG"; then
  exit 0
fi
exit 1

// File: testbench/program_golden.hex
// Section: N, N instruction words, D, D pairs of (DM address, data),
// S, S pairs of expected (DM address, data) stores, final ins_cnt
// A section with N of ffffffff ends the file

// ALU ops and immediates: MOVI ADDI ORI ADD SUB AND OR XOR SLLI SRLI, then SWI
00000014
441ffffb 50208064 58316a00 40410c00 40510401
40620c02 40729804 40808c03 40911008 40a0f009
14100010 14200011 14300012 14400013 14500014
14600015 14700016 14800017 14900018 14a17fe0
00000000
0000000a
00000010 fffffffb  00000011 0000005f  00000012 00006a5f  00000013 00006abe
00000014 00000064  00000015 00006a1e  00000016 00006a7e  00000017 ffff95a4
00000018 000005f0  0000003f 0000000f
00000014

// Loads, writes to r0 and an unknown opcode
0000000b
44100100 04208000 04308001 40410c03 50010001 04008000
14408002 14008003 40500800 7e500000 14508004
00000002
00000100 12345678  00000101 0f0f0f0f
00000003
00000102 1d3b5977  00000103 00000000  00000104 12345678
0000000b

// BNE loop of three trips, BEQ taken and not taken, forward J
0000000e
44100003 44200000 50210001 14210020 4c117ffe 4c110002 14100030
48000002 14100031 4c010002 14100032 48000002 14100033 14200034
00000000
00000005
00000021 00000001  00000022 00000002  00000023 00000003
00000032 00000003  00000034 00000003
00000011

// Empty program
00000000 00000000 00000000 00000000

ffffffff

// File: testbench/tb_top.sv
`timescale 1ns/1ns

module tb_top;

  localparam int IM_AW      = 10;
  localparam int DM_AW      = 15;
  localparam int ROM_AW     = 11;
  localparam int CYCLE_W    = 64;
  localparam int INS_W      = 32;
  localparam int PERIOD     = 40;
  localparam int GOLD_WORDS = 256;
  localparam int DONE_WATCH = 20;  // Cycles watched after done

  logic               clk           = 1'b0;
  logic               arst_n        = 1'b0;
  logic               system_enable = 1'b0;
  logic               rom_read;
  logic [ROM_AW-1:0]  rom_addr;
  logic [31:0]        rom_data      = '0;
  logic               im_read;
  logic               im_write;
  logic [IM_AW-1:0]   im_addr;
  logic [31:0]        im_wdata;
  logic [31:0]        im_rdata      = '0;
  logic               dm_read;
  logic               dm_write;
  logic [DM_AW-1:0]   dm_addr;
  logic [31:0]        dm_wdata;
  logic [31:0]        dm_rdata      = '0;
  logic               done;
  logic [CYCLE_W-1:0] cycle_cnt;
  logic [INS_W-1:0]   ins_cnt;

  logic [31:0] rom_mem [2**ROM_AW];
  logic [31:0] im_mem  [2**IM_AW];
  logic [31:0] dm_mem  [2**DM_AW];
  logic [31:0] dm_init [2**DM_AW];  // DM contents for the next section
  logic [31:0] golden  [GOLD_WORDS];

  longint limit_ns  = 0;
  int     test_pass = 0;
  int     test_fail = 0;

  top #(
    .IM_AW(IM_AW), .DM_AW(DM_AW), .ROM_AW(ROM_AW), .CYCLE_W(CYCLE_W), .INS_W(INS_W)
  ) top_i (
    .clk(clk), .arst_n(arst_n), .system_enable(system_enable),
    .rom_read(rom_read), .rom_addr(rom_addr), .rom_data(rom_data),
    .im_read(im_read), .im_write(im_write), .im_addr(im_addr),
    .im_wdata(im_wdata), .im_rdata(im_rdata),
    .dm_read(dm_read), .dm_write(dm_write), .dm_addr(dm_addr),
    .dm_wdata(dm_wdata), .dm_rdata(dm_rdata),
    .done(done), .cycle_cnt(cycle_cnt), .ins_cnt(ins_cnt));

  always #(PERIOD / 2) clk = ~clk;

  // ========================================================================
  // Memory models with a one-cycle synchronous read
  // ========================================================================
  always @(posedge clk) begin
    if (rom_read) rom_data <= rom_mem[rom_addr];
    if (im_read) im_rdata <= im_mem[im_addr];
    if (im_write) im_mem[im_addr] <= im_wdata;
    if (dm_read) dm_rdata <= dm_mem[dm_addr];
    if (!arst_n) begin
      dm_mem <= dm_init;  // Preload while reset is held
    end else if (dm_write) begin
      dm_mem[dm_addr] <= dm_wdata;
    end
  end

  function automatic longint run_budget();
    int     p;
    int     n;
    longint cycles;
    p      = 0;
    cycles = DONE_WATCH + 11;  // Closing reset test
    while (p < GOLD_WORDS && golden[p] !== 32'hffff_ffff) begin
      n = int'(golden[p]);
      p = p + 1 + n;
      p = p + 1 + 2 * int'(golden[p]);
      p = p + 1 + 2 * int'(golden[p]);
      cycles = cycles + n + 3 + 5 * longint'(golden[p]) + 50;
      p = p + 1;
    end
    return cycles * PERIOD;
  endfunction

  task automatic report_test(input int idx, input string what, input int errs);
    if (errs == 0) begin
      test_pass++;
      $display("Test %0d %s: ok", idx, what);
    end else begin
      test_fail++;
      $display("Test %0d %s: %0d errors", idx, what, errs);
    end
  endtask

  task automatic apply_reset(inout int errs);
    arst_n        = 1'b0;
    system_enable = 1'b0;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    if (done !== 1'b0) begin
      $display("Error: done %h expected %h after reset", done, 1'b0);
      errs++;
    end
    if (ins_cnt !== '0) begin
      $display("Error: ins_cnt %h expected %h after reset", ins_cnt, 0);
      errs++;
    end
    if (cycle_cnt !== '0) begin
      $display("Error: cycle_cnt %h expected %h after reset", cycle_cnt, 0);
      errs++;
    end
  endtask

  // ========================================================================
  // One golden section loads, runs to done and then watches the idle machine
  // ========================================================================
  task automatic run_section(input int idx, inout int p);
    int                 i;
    int                 n;
    int                 d;
    int                 s;
    int                 img;     // Golden index of the first instruction
    int                 st;      // Golden index of the first expected store
    int                 loads;
    int                 stores;
    int                 errs;
    logic [31:0]        exp_ins;
    logic [CYCLE_W-1:0] exp_cycles;  // Cycles since system_enable rose
    n   = int'(golden[p]);
    img = p + 1;
    p   = img + n;
    d   = int'(golden[p]);
    for (i = 0; i < 2 ** DM_AW; i++) begin
      dm_init[i] = '0;
    end
    for (i = 0; i < d; i++) begin
      dm_init[golden[p + 1 + 2 * i][DM_AW-1:0]] = golden[p + 2 + 2 * i];
    end
    p       = p + 1 + 2 * d;
    s       = int'(golden[p]);
    st      = p + 1;
    p       = st + 2 * s;
    exp_ins = golden[p];
    p       = p + 1;
    rom_mem[0] = golden[img - 1];
    for (i = 0; i < n; i++) begin
      rom_mem[i + 1] = golden[img + i];
    end
    errs       = 0;
    loads      = 0;
    stores     = 0;
    exp_cycles = '0;
    apply_reset(errs);
    system_enable = 1'b1;
    while (done !== 1'b1) begin
      @(negedge clk);
      exp_cycles = exp_cycles + 1'b1;
      if (im_write === 1'b1) begin
        if (loads >= n) begin
          $display("Loader wrote more IM words than the program holds");
          errs++;
        end else if (im_addr !== IM_AW'(loads) || im_wdata !== golden[img + loads]) begin
          $display("Error: im_addr %h im_wdata %h expected %h %h",
                   im_addr, im_wdata, IM_AW'(loads), golden[img + loads]);
          errs++;
        end
        loads++;
      end
      if (dm_write === 1'b1) begin
        if (stores >= s) begin
          $display("Store to DM beyond the expected list");
          errs++;
        end else begin
          if (dm_addr !== golden[st + 2 * stores][DM_AW-1:0]) begin
            $display("Error: dm_addr %h expected %h", dm_addr,
                     golden[st + 2 * stores][DM_AW-1:0]);
            errs++;
          end
          if (dm_wdata !== golden[st + 2 * stores + 1]) begin
            $display("Error: dm_wdata %h expected %h", dm_wdata, golden[st + 2 * stores + 1]);
            errs++;
          end
        end
        stores++;
      end
    end
    if (loads != n || stores != s) begin
      $display("Saw %0d IM writes and %0d stores, expected %0d and %0d", loads, stores, n, s);
      errs++;
    end
    if (ins_cnt !== exp_ins) begin
      $display("Error: ins_cnt %h expected %h", ins_cnt, exp_ins);
      errs++;
    end
    repeat (DONE_WATCH) begin
      @(negedge clk);
      if (done !== 1'b1 || dm_write !== 1'b0 || im_read !== 1'b0) begin
        $display("Done dropped or a memory strobe came after the end of program");
        errs++;
      end
    end
    if (cycle_cnt !== exp_cycles) begin
      $display("Error: cycle_cnt %h expected %h", cycle_cnt, exp_cycles);
      errs++;
    end
    report_test(idx, $sformatf("(%0d words, %0d stores)", n, s), errs);
  endtask

  initial begin : watchdog
    wait (limit_ns > 0);
    #(limit_ns);
    $display("Timeout after %0d ns, done never came", limit_ns);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : main
    int p;
    int idx;
    int errs;
    p   = 0;
    idx = 1;
    $readmemh("testbench/program_golden.hex", golden);
    limit_ns = run_budget();
    while (p < GOLD_WORDS && golden[p] !== 32'hffff_ffff) begin
      run_section(idx, p);
      idx++;
    end
    errs = 0;
    apply_reset(errs);  // Counters and done clear after a finished run
    report_test(idx, "reset after done", errs);
    $display("Tests run: %0d, passed: %0d, failed: %0d", idx, test_pass, test_fail);
    if (test_fail == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: verilog.f
hw/cpu_pkg.sv
hw/rom_loader.sv
hw/pc_tick.sv
hw/ir_controller.sv
hw/regfile.sv
hw/alu32.sv
hw/top.sv
testbench/tb_top.sv
